//--- design/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

////////////////////////////////////////////////////////////
// memory geometry
////////////////////////////////////////////////////////////
`define MEM_ADDR_W      15   // word address, 32K words of 32 bits

// width of the access wait counter
// all ones marks the last of the 4 access cycles
`define MEM_WAIT_CNT_W  2

////////////////////////////////////////////////////////////
// data cache geometry
////////////////////////////////////////////////////////////
`define CACHE_IDX_W     4    // 16 direct-mapped one-word lines

`endif

//--- design/mem_pkg.sv
`default_nettype none
`include "mem_config.svh"

package mem_pkg;

  ////////////////////////////////////////////////////////////
  // memory bus types
  ////////////////////////////////////////////////////////////
  typedef logic [31:0] word_t;              // one memory word
  typedef logic [`MEM_ADDR_W-1:0] addr_t;   // word address into unified_mem

  // request from the arbiter into the memory
  // re and we are held for one cycle per access
  typedef struct packed {
    addr_t addr;     // word address
    logic  re;       // read request
    logic  we;       // write request
    word_t wdata;    // write data
  } mem_req_t;

endpackage

`default_nettype wire

//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  ////////////////////////////////////////////////////////////
  // cpu-side port types
  ////////////////////////////////////////////////////////////

  // data port request, held until done
  typedef struct packed {
    mem_pkg::addr_t addr;    // word address
    logic           re;      // load
    logic           we;      // store
    mem_pkg::word_t wdata;   // store data
  } data_req_t;

  // instruction fetch request, read only
  typedef struct packed {
    mem_pkg::addr_t addr;    // fetch address
    logic           re;      // fetch strobe
  } fetch_req_t;

  // response on either port
  typedef struct packed {
    mem_pkg::word_t rdata;   // valid with done on reads
    logic           done;    // one-cycle completion pulse
  } rsp_t;

endpackage

`default_nettype wire

//--- design/unified_mem.sv
`timescale 1ns/100ps
`default_nettype none
`include "mem_config.svh"

module unified_mem (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire mem_pkg::mem_req_t mem_req,
  output mem_pkg::word_t         rd_data,   // registered on the completion edge
  output logic                   rdy        // high in idle and in the last access cycle
);

  localparam int HALF_AW = `MEM_ADDR_W + 1;  // half-word address width

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    WRITE = 2'b01,
    READ  = 2'b10
  } state_t;

  logic [15:0] mem [0:(1 << HALF_AW)-1];    // whole space as 16-bit half-words

  state_t                     state, nxt_state;
  logic [`MEM_WAIT_CNT_W-1:0] wait_cnt;     // counts the 4 access cycles
  mem_pkg::addr_t             addr_q;       // address held for the whole access
  mem_pkg::word_t             wdata_q;      // write data held likewise
  logic                       accept;       // request taken at this edge
  logic                       last_cyc;     // final access cycle
  logic                       int_we, int_re;

  ////////////////////////////////////////////////////////////
  // handshake decode
  ////////////////////////////////////////////////////////////
  assign accept   = (state == IDLE) & (mem_req.re | mem_req.we);
  assign last_cyc = (state != IDLE) & (&wait_cnt);
  assign int_we   = last_cyc & (state == WRITE);
  assign int_re   = last_cyc & (state == READ);
  assign rdy      = (state == IDLE) | last_cyc;

  // write wins if both strobes show up together
  always_comb begin
    nxt_state = state;
    case (state)
      IDLE: begin
        if (mem_req.we)
          nxt_state = WRITE;
        else if (mem_req.re)
          nxt_state = READ;
      end
      WRITE, READ: begin
        if (last_cyc)
          nxt_state = IDLE;     // access done, back to idle
      end
      default: nxt_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  // counter sits at zero while idle, wraps back on the last cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      wait_cnt <= '0;
    else if (state == IDLE)
      wait_cnt <= '0;
    else
      wait_cnt <= wait_cnt + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // capture and array access
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= mem_req.addr;
      wdata_q <= mem_req.wdata;
    end
  end

  // word a is half-words 2a (low) and 2a+1 (high)
  always_ff @(posedge clk) begin
    if (int_we) begin
      mem[{addr_q, 1'b0}] <= wdata_q[15:0];
      mem[{addr_q, 1'b1}] <= wdata_q[31:16];
    end
  end

  always_ff @(posedge clk) begin
    if (int_re)
      rd_data <= {mem[{addr_q, 1'b1}], mem[{addr_q, 1'b0}]};  // same order as written
  end

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire cpu_pkg::fetch_req_t fetch_req,
  output cpu_pkg::rsp_t           fetch_rsp,
  input  wire cpu_pkg::data_req_t dc_req,     // miss and write-through traffic
  output cpu_pkg::rsp_t           dc_rsp,
  output mem_pkg::mem_req_t       mem_req,
  input  wire mem_pkg::word_t     rd_data,
  input  wire logic               rdy
);

  logic           issue_re, issue_we;   // single-cycle strobes to memory
  mem_pkg::addr_t issue_addr;
  mem_pkg::word_t issue_wdata;
  logic           busy;                 // access accepted, not yet complete
  logic           owner_dc;             // 1 when the data side owns the access
  logic           done_q;               // completion pulse to the owner
  logic           dc_want, fetch_want;
  logic           issued;               // strobe on the bus this cycle
  logic           can_grant;
  logic           grant_dc, grant_fetch;
  logic           complete;             // last access cycle of memory

  ////////////////////////////////////////////////////////////
  // grant decode
  ////////////////////////////////////////////////////////////
  assign dc_want    = dc_req.re | dc_req.we;
  assign fetch_want = fetch_req.re;
  assign issued     = issue_re | issue_we;

  // memory idle and no pulse pending
  // the done cycle is skipped so a held request is not taken twice
  assign can_grant   = rdy & ~busy & ~issued & ~done_q;
  assign grant_dc    = can_grant & dc_want;                 // data side wins ties
  assign grant_fetch = can_grant & ~dc_want & fetch_want;
  assign complete    = busy & rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_re <= 1'b0;
      issue_we <= 1'b0;
      owner_dc <= 1'b0;
      busy     <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      if (grant_dc) begin
        issue_re <= dc_req.re & ~dc_req.we;
        issue_we <= dc_req.we;
        owner_dc <= 1'b1;
      end else if (grant_fetch) begin
        issue_re <= 1'b1;
        issue_we <= 1'b0;
        owner_dc <= 1'b0;
      end else begin
        issue_re <= 1'b0;                     // strobe lasts one cycle
        issue_we <= 1'b0;
      end
      if (issued)
        busy <= 1'b1;                         // memory accepts on this edge
      else if (complete)
        busy <= 1'b0;
      done_q <= complete;                     // rd_data is registered by now
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (grant_dc) begin
      issue_addr  <= dc_req.addr;
      issue_wdata <= dc_req.wdata;
    end else if (grant_fetch) begin
      issue_addr  <= fetch_req.addr;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus and response routing
  ////////////////////////////////////////////////////////////
  always_comb begin
    mem_req.addr    = issue_addr;
    mem_req.re      = issue_re;
    mem_req.we      = issue_we;
    mem_req.wdata   = issue_wdata;
    dc_rsp.rdata    = rd_data;
    dc_rsp.done     = done_q & owner_dc;
    fetch_rsp.rdata = rd_data;
    fetch_rsp.done  = done_q & ~owner_dc;
  end

endmodule

`default_nettype wire

//--- design/data_cache.sv
`timescale 1ns/100ps
`default_nettype none
`include "mem_config.svh"

module data_cache (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire cpu_pkg::data_req_t cpu_req,
  output cpu_pkg::rsp_t           cpu_rsp,
  output cpu_pkg::data_req_t      mem_side_req,   // toward the arbiter
  input  wire cpu_pkg::rsp_t      mem_side_rsp
);

  localparam int IDX_W = `CACHE_IDX_W;
  localparam int TAG_W = `MEM_ADDR_W - `CACHE_IDX_W;
  localparam int LINES = 1 << IDX_W;

  typedef enum logic [1:0] {
    C_IDLE  = 2'b00,   // waiting for a request
    C_HIT   = 2'b01,   // read hit, respond next cycle
    C_MISS  = 2'b10,   // line fill in flight
    C_WRITE = 2'b11    // write-through in flight
  } state_t;

  ////////////////////////////////////////////////////////////
  // line storage
  ////////////////////////////////////////////////////////////
  mem_pkg::word_t   data_mem [0:LINES-1];
  logic [TAG_W-1:0] tag_mem  [0:LINES-1];
  logic [LINES-1:0] valid;

  state_t           state;
  mem_pkg::word_t   hit_data_q;      // line word held for the hit response
  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic             hit;
  logic             fill;            // miss data back from memory

  assign idx  = cpu_req.addr[IDX_W-1:0];
  assign tag  = cpu_req.addr[`MEM_ADDR_W-1:IDX_W];
  assign hit  = valid[idx] & (tag_mem[idx] == tag);
  assign fill = (state == C_MISS) & mem_side_rsp.done;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= C_IDLE;
    end else begin
      case (state)
        C_IDLE: begin
          if (cpu_req.we)
            state <= C_WRITE;          // every store goes through
          else if (cpu_req.re)
            state <= hit ? C_HIT : C_MISS;
        end
        C_HIT:
          state <= C_IDLE;
        C_MISS, C_WRITE: begin
          if (mem_side_rsp.done)
            state <= C_IDLE;
        end
        default:
          state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      valid <= '0;
    else if (fill)
      valid[idx] <= 1'b1;
  end

  // data and tags update on a fill or on a store that hits
  // a store miss leaves the resident line alone
  always_ff @(posedge clk) begin
    if (state == C_IDLE && cpu_req.we && hit)
      data_mem[idx] <= cpu_req.wdata;
    else if (fill) begin
      data_mem[idx] <= mem_side_rsp.rdata;
      tag_mem[idx]  <= tag;
    end
  end

  always_ff @(posedge clk) begin
    if (state == C_IDLE && cpu_req.re && hit)
      hit_data_q <= data_mem[idx];
  end

  ////////////////////////////////////////////////////////////
  // ports
  ////////////////////////////////////////////////////////////
  always_comb begin
    // cpu request stays held so it can drive the memory side directly
    mem_side_req.addr  = cpu_req.addr;
    mem_side_req.wdata = cpu_req.wdata;
    mem_side_req.re    = (state == C_MISS);
    mem_side_req.we    = (state == C_WRITE);

    cpu_rsp.done  = (state == C_HIT) |
                    (((state == C_MISS) | (state == C_WRITE)) & mem_side_rsp.done);
    cpu_rsp.rdata = (state == C_HIT) ? hit_data_q : mem_side_rsp.rdata;
  end

endmodule

`default_nettype wire

//--- design/mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire cpu_pkg::data_req_t  data_req,    // data port
  output cpu_pkg::rsp_t            data_rsp,
  input  wire cpu_pkg::fetch_req_t fetch_req,   // instruction port, uncached
  output cpu_pkg::rsp_t            fetch_rsp
);

  ////////////////////////////////////////////////////////////
  // internal buses
  ////////////////////////////////////////////////////////////
  cpu_pkg::data_req_t dc_mem_req;   // cache miss and write-through
  cpu_pkg::rsp_t      dc_mem_rsp;
  mem_pkg::mem_req_t  mem_req;      // arbiter to memory
  mem_pkg::word_t     mem_rd_data;
  logic               mem_rdy;

  // data cache on the data port
  data_cache dc0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpu_req      (data_req),
    .cpu_rsp      (data_rsp),
    .mem_side_req (dc_mem_req),
    .mem_side_rsp (dc_mem_rsp)
  );

  // fetch and cache traffic share one memory
  mem_arbiter arb0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .dc_req    (dc_mem_req),
    .dc_rsp    (dc_mem_rsp),
    .mem_req   (mem_req),
    .rd_data   (mem_rd_data),
    .rdy       (mem_rdy)
  );

  // 4-cycle unified memory
  unified_mem mem0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .rd_data (mem_rd_data),
    .rdy     (mem_rdy)
  );

endmodule

`default_nettype wire

//--- bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////
task automatic check_word(input string sig, input int a,
                          input mem_pkg::word_t got, input mem_pkg::word_t exp);
  if (got !== exp) begin
    val_errs++;
    $display("** Error at %0t ns: %s addr %0d got %h expected %h", $time, sig, a, got, exp);
  end
endtask

// cycles counted from the request edge to the done cycle
task automatic check_latency(input string sig, input int a, input int got, input int exp);
  if (got != exp) begin
    lat_errs++;
    $display("** Error at %0t ns: %s latency addr %0d got %0d expected %0d",
             $time, sig, a, got, exp);
  end
endtask

// one-bit completion strobes
task automatic check_done(input string sig, input logic got, input logic exp);
  if (got !== exp) begin
    val_errs++;
    $display("** Error at %0t ns: %s got %b expected %b", $time, sig, got, exp);
  end
endtask

////////////////////////////////////////////////////////////
// bounded wait for done
////////////////////////////////////////////////////////////
task automatic wait_done(input bit on_fetch, output int cycles, output mem_pkg::word_t rd);
  bit    seen;
  string port;
  seen   = 1'b0;
  cycles = 0;
  rd     = '0;
  while (!seen && cycles < TIMEOUT_CYC) begin
    @(posedge clk);
    cycles++;
    @(negedge clk);                          // outputs settled mid-cycle
    seen = on_fetch ? fetch_rsp.done : data_rsp.done;
  end
  if (seen)
    rd = on_fetch ? fetch_rsp.rdata : data_rsp.rdata;
  else begin
    port = "data";
    if (on_fetch)
      port = "fetch";
    tmo_errs++;
    $display("timeout at %0t ns: the %s port gave no done within %0d cycles",
             $time, port, TIMEOUT_CYC);
  end
endtask

`endif

//--- bench/tb_mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsystem;

  localparam int TIMEOUT_CYC = 64;   // per-request bound
  localparam int N_MIX_DATA  = 40;
  localparam int N_MIX_FETCH = 30;

  logic               clk;
  logic               rst_n;
  cpu_pkg::data_req_t data_req;
  cpu_pkg::rsp_t      data_rsp;
  cpu_pkg::fetch_req_t fetch_req;
  cpu_pkg::rsp_t      fetch_rsp;

  integer         seed;
  mem_pkg::word_t model [0:63];      // reference image of words 0..63
  int             val_errs, lat_errs, tmo_errs;

  `include "tb_checks.svh"

  mem_subsystem dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_req  (data_req),
    .data_rsp  (data_rsp),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;          // 40 ns period
  end

  ////////////////////////////////////////////////////////////
  // random helpers and port drivers
  ////////////////////////////////////////////////////////////
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic mem_pkg::word_t rand_word();
    mem_pkg::word_t r;
    r = $random(seed);
    return r;
  endfunction

  // one data-port access, request held until done, then released
  task automatic data_op(input int a, input bit wr, input mem_pkg::word_t w,
                         output int cycles, output mem_pkg::word_t rd);
    @(posedge clk);
    #2;
    data_req.addr  = mem_pkg::addr_t'(a);
    data_req.re    = ~wr;
    data_req.we    = wr;
    data_req.wdata = w;
    wait_done(1'b0, cycles, rd);
    @(posedge clk);
    #2;
    data_req = '0;                   // idle after the done cycle
  endtask

  task automatic data_write(input int a, input mem_pkg::word_t w);
    int             cycles;
    mem_pkg::word_t rd;
    data_op(a, 1'b1, w, cycles, rd);
    model[a] = w;
  endtask

  // exp_lat of zero skips the latency compare
  task automatic data_read_check(input int a, input int exp_lat);
    int             cycles;
    mem_pkg::word_t rd;
    data_op(a, 1'b0, '0, cycles, rd);
    check_word("data_rsp.rdata", a, rd, model[a]);
    if (exp_lat > 0)
      check_latency("data_rsp.done", a, cycles, exp_lat);
  endtask

  task automatic fetch_op(input int a, output int cycles, output mem_pkg::word_t rd);
    @(posedge clk);
    #2;
    fetch_req.addr = mem_pkg::addr_t'(a);
    fetch_req.re   = 1'b1;
    wait_done(1'b1, cycles, rd);
    @(posedge clk);
    #2;
    fetch_req = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // mixed traffic, fetches only touch 32..63
  ////////////////////////////////////////////////////////////
  task automatic data_traffic(input int n);
    int a;
    for (int i = 0; i < n; i++) begin
      a = rand_below(32);
      if (rand_below(2) == 1)
        data_write(a, rand_word());
      else
        data_read_check(a, 0);
    end
  endtask

  task automatic fetch_traffic(input int n);
    int             a, cycles;
    mem_pkg::word_t rd;
    for (int i = 0; i < n; i++) begin
      repeat (rand_below(4)) @(posedge clk);   // uneven spacing vs data side
      a = 32 + rand_below(32);
      fetch_op(a, cycles, rd);
      check_word("fetch_rsp.rdata", a, rd, model[a]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int             a, b, cycles;
    mem_pkg::word_t rd;
    seed      = 32'h8e84_63b8;
    val_errs  = 0;
    lat_errs  = 0;
    tmo_errs  = 0;
    data_req  = '0;
    fetch_req = '0;
    rst_n     = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_done("data_rsp.done", data_rsp.done, 1'b0);
    check_done("fetch_rsp.done", fetch_rsp.done, 1'b0);

    for (int i = 0; i < 64; i++)     // preload, every line starts empty
      data_write(i, rand_word());
    for (int i = 0; i < 64; i++)     // half-word order readback
      data_read_check(i, 0);

    repeat (4) begin                 // second read of a line must hit
      a = rand_below(32);
      data_read_check(a, 0);
      data_read_check(a, 1);
    end

    repeat (4) begin                 // write-through then eviction by alias
      a = rand_below(32);
      data_read_check(a, 0);         // line resident, so the store hits
      data_write(a, rand_word());
      data_read_check(a, 1);         // new word straight from the line
      data_read_check(a ^ 16, 0);
      data_read_check(a, 0);         // refilled from memory
    end

    repeat (4) begin                 // store miss leaves resident line valid
      a = rand_below(32);
      b = a ^ 16;                    // same index, other tag
      data_read_check(a, 0);
      data_write(b, rand_word());
      data_read_check(a, 1);
      data_read_check(b, 0);
    end

    fork
      data_traffic(N_MIX_DATA);
      fetch_traffic(N_MIX_FETCH);
    join

    a = 32 + rand_below(32);         // lone fetch, data port quiet
    fetch_op(a, cycles, rd);
    check_word("fetch_rsp.rdata", a, rd, model[a]);
    check_latency("fetch_rsp.done", a, cycles, 6);

    $display("errors: value %0d, latency %0d, timeout %0d", val_errs, lat_errs, tmo_errs);
    if (val_errs + lat_errs + tmo_errs == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
+incdir+bench
design/mem_pkg.sv
design/cpu_pkg.sv
design/unified_mem.sv
design/mem_arbiter.sv
design/data_cache.sv
design/mem_subsystem.sv
bench/tb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build the memory subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f \
  --top-module tb_mem_subsystem -Mdir obj_dir -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "sim passed"
